// File: alu_ctrl_fsm.sv
`timescale 1ns/1ps

module alu_ctrl_fsm
    import alu_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  logic    i_in_valid,
    input  alu_op_e i_inst,
    input  logic    i_last,
    output logic    o_busy,
    output logic    o_accept,
    output logic    o_iter_start,
    output logic    o_step_en,
    output logic    o_out_strobe,
    output logic    o_sel_iter
);

    alu_state_e state;
    alu_state_e state_nxt;

    // single-step result due on the next edge
    logic pending;

    logic is_iter;

    // rot, clz and lrcw take several cycles
    assign is_iter = (i_inst inside {OP_ROT, OP_CLZ, OP_LRCW});

    // busy covers iteration and the finish cycle
    assign o_busy = (state != ST_IDLE);

    // requests while busy are dropped, not stalled
    assign o_accept     = i_in_valid && !o_busy;
    assign o_iter_start = o_accept && is_iter;

    // no step once the finish condition holds
    assign o_step_en = (state == ST_ITER) && !i_last;

    // write a result one cycle after a single-step accept or in finish
    assign o_out_strobe = pending || (state == ST_FINISH);
    assign o_sel_iter   = (state == ST_FINISH);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (o_iter_start) begin
                    state_nxt = ST_ITER;
                end
            end
            ST_ITER: begin
                if (i_last) begin
                    state_nxt = ST_FINISH;
                end
            end
            ST_FINISH: begin
                state_nxt = ST_IDLE;
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= ST_IDLE;
            pending <= 1'b0;
        end else begin
            state   <= state_nxt;
            // one-cycle flag, a new accept can follow right behind
            pending <= o_accept && !is_iter;
        end
    end

endmodule

// File: alu_iter_unit.sv
`timescale 1ns/1ps

module alu_iter_unit
    import alu_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_start,
    input  logic              i_step_en,
    input  alu_op_e           i_inst,
    input  logic [DATA_W-1:0] i_data_a,
    input  logic [DATA_W-1:0] i_data_b,
    input  logic [STEP_W-1:0] i_step,
    output logic              o_last,
    output logic [DATA_W-1:0] o_iter_result
);

    alu_op_e           op_q;
    logic [DATA_W-1:0] a_q;
    logic [3:0]        amt_q;
    logic [DATA_W-1:0] work_q;

    // low step bits index into operand a
    logic [STEP_W-2:0] bit_idx;
    logic [STEP_W-2:0] clz_idx;
    logic              lrcw_ctl;
    logic              clz_hit;

    assign bit_idx = i_step[STEP_W-2:0];

    // lrcw control bit walks from lsb up
    assign lrcw_ctl = a_q[bit_idx];

    // clz tests from the msb down
    assign clz_idx = (STEP_W-1)'(DATA_W - 1) - bit_idx;
    assign clz_hit = a_q[clz_idx];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            op_q   <= OP_ADD;
            a_q    <= '0;
            amt_q  <= '0;
            work_q <= '0;
        end else if (i_start) begin
            op_q  <= i_inst;
            a_q   <= i_data_a;
            amt_q <= i_data_b[3:0];
            // lrcw works on b, rot works on a
            work_q <= (i_inst == OP_LRCW) ? i_data_b : i_data_a;
        end else if (i_step_en) begin
            case (op_q)
                OP_ROT: begin
                    // rotate right by one
                    work_q <= {work_q[0], work_q[DATA_W-1:1]};
                end
                OP_LRCW: begin
                    // shift left, refill with the inverted old msb
                    if (lrcw_ctl) begin
                        work_q <= {work_q[DATA_W-2:0], ~work_q[DATA_W-1]};
                    end
                end
                default: begin
                    // clz only counts
                    work_q <= work_q;
                end
            endcase
        end
    end

    // finish conditions per operation
    always_comb begin
        case (op_q)
            OP_ROT:  o_last = (i_step == {1'b0, amt_q});
            OP_LRCW: o_last = (i_step == STEP_W'(LRCW_STEPS));
            // zero operand runs to 16 like lrcw
            OP_CLZ:  o_last = (i_step == STEP_W'(DATA_W)) || clz_hit;
            default: o_last = 1'b1;
        endcase
    end

    // clz result is the count itself, 0 to 16
    assign o_iter_result = (op_q == OP_CLZ) ? {{(DATA_W-STEP_W){1'b0}}, i_step} : work_q;

endmodule

// File: alu_pkg.sv
package alu_pkg;

    // operand and result width
    localparam int DATA_W = 16;

    // opcode field width
    localparam int INST_W = 4;

    // step counter width, must reach 16
    localparam int STEP_W = 5;

    // lrcw always walks every bit of operand a
    localparam int LRCW_STEPS = 16;

    // signed saturation limits
    localparam logic [DATA_W-1:0] SAT_MAX = {1'b0, {(DATA_W-1){1'b1}}};
    localparam logic [DATA_W-1:0] SAT_MIN = {1'b1, {(DATA_W-1){1'b0}}};

    // opcodes, gaps are unused codes that return zero
    typedef enum logic [INST_W-1:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_GRAY = 4'd4,
        OP_LRCW = 4'd5,
        OP_ROT  = 4'd6,
        OP_CLZ  = 4'd7
    } alu_op_e;

    // control states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ITER,
        ST_FINISH
    } alu_state_e;

endpackage

// File: alu_result_stage.sv
`timescale 1ns/1ps

module alu_result_stage
    import alu_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_accept,
    input  logic              i_out_strobe,
    input  logic              i_sel_iter,
    input  alu_op_e           i_inst,
    input  logic [DATA_W-1:0] i_data_a,
    input  logic [DATA_W-1:0] i_data_b,
    input  logic [DATA_W-1:0] i_iter_result,
    output logic [DATA_W-1:0] o_data,
    output logic              o_out_valid
);

    alu_op_e           op_q;
    logic [DATA_W-1:0] a_q;
    logic [DATA_W-1:0] b_q;

    logic [DATA_W:0]   sum;
    logic              ovf;
    logic [DATA_W-1:0] sat_out;
    logic [DATA_W-1:0] gray_out;
    logic [DATA_W-1:0] single_out;

    // operand register, second in-flight slot
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            op_q <= OP_ADD;
            a_q  <= '0;
            b_q  <= '0;
        end else if (i_accept) begin
            op_q <= i_inst;
            a_q  <= i_data_a;
            b_q  <= i_data_b;
        end
    end

    // exact sum in one extra bit, no corner case at -32768
    always_comb begin
        if (op_q == OP_SUB) begin
            sum = {a_q[DATA_W-1], a_q} - {b_q[DATA_W-1], b_q};
        end else begin
            sum = {a_q[DATA_W-1], a_q} + {b_q[DATA_W-1], b_q};
        end
    end

    // top two bits disagree on overflow
    assign ovf = sum[DATA_W] ^ sum[DATA_W-1];

    // clamp direction follows the sign of a
    assign sat_out = !ovf ? sum[DATA_W-1:0] : (a_q[DATA_W-1] ? SAT_MIN : SAT_MAX);

    // each bit xor its upper neighbour, msb passes through
    assign gray_out = a_q ^ {1'b0, a_q[DATA_W-1:1]};

    always_comb begin
        case (op_q)
            OP_ADD:  single_out = sat_out;
            OP_SUB:  single_out = sat_out;
            OP_GRAY: single_out = gray_out;
            // unknown codes give zero
            default: single_out = '0;
        endcase
    end

    // output register, value holds until the next strobe
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_data      <= '0;
            o_out_valid <= 1'b0;
        end else begin
            o_out_valid <= i_out_strobe;
            if (i_out_strobe) begin
                o_data <= i_sel_iter ? i_iter_result : single_out;
            end
        end
    end

endmodule

// File: alu_step_counter.sv
`timescale 1ns/1ps

module alu_step_counter
    import alu_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_clear,
    input  logic              i_advance,
    output logic [STEP_W-1:0] o_step
);

    logic at_max;

    // hold at 16, the longest run of any operation
    assign at_max = (o_step == STEP_W'(LRCW_STEPS));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_step <= '0;
        end else if (i_clear) begin
            // new iterative request
            o_step <= '0;
        end else if (i_advance && !at_max) begin
            o_step <= o_step + 1'b1;
        end
    end

endmodule

// File: alu_top.sv
`timescale 1ns/1ps

module alu_top
    import alu_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_in_valid,
    input  logic [INST_W-1:0] i_inst,
    input  logic [DATA_W-1:0] i_data_a,
    input  logic [DATA_W-1:0] i_data_b,
    output logic              o_busy,
    output logic              o_out_valid,
    output logic [DATA_W-1:0] o_data
);

    alu_op_e           inst_op;
    logic              accept;
    logic              iter_start;
    logic              step_en;
    logic              out_strobe;
    logic              sel_iter;
    logic              last;
    logic [STEP_W-1:0] step;
    logic [DATA_W-1:0] iter_result;

    // raw opcode field onto the enum, unused codes pass through
    assign inst_op = alu_op_e'(i_inst);

    alu_ctrl_fsm u_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_in_valid   (i_in_valid),
        .i_inst       (inst_op),
        .i_last       (last),
        .o_busy       (o_busy),
        .o_accept     (accept),
        .o_iter_start (iter_start),
        .o_step_en    (step_en),
        .o_out_strobe (out_strobe),
        .o_sel_iter   (sel_iter)
    );

    // one counter shared by rot, clz and lrcw
    alu_step_counter u_step (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_clear   (iter_start),
        .i_advance (step_en),
        .o_step    (step)
    );

    alu_iter_unit u_iter (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_start       (iter_start),
        .i_step_en     (step_en),
        .i_inst        (inst_op),
        .i_data_a      (i_data_a),
        .i_data_b      (i_data_b),
        .i_step        (step),
        .o_last        (last),
        .o_iter_result (iter_result)
    );

    alu_result_stage u_result (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_accept      (accept),
        .i_out_strobe  (out_strobe),
        .i_sel_iter    (sel_iter),
        .i_inst        (inst_op),
        .i_data_a      (i_data_a),
        .i_data_b      (i_data_b),
        .i_iter_result (iter_result),
        .o_data        (o_data),
        .o_out_valid   (o_out_valid)
    );

endmodule

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it, exit status follows the run
cd "$(dirname "$0")" \
    && verilator --binary --assert -Wno-fatal --top-module tb_alu -f vlog.f -o tb_alu \
    && ./obj_dir/tb_alu \
    || exit 1

// File: tb_alu.sv
`timescale 1ns/1ps

module tb_alu
    import alu_pkg::*;
;

    // request counts per test group
    localparam int N_ARITH     = 30;
    localparam int N_OVF       = 6;
    localparam int N_GRAY      = 20;
    localparam int N_UNKNOWN   = 3;
    localparam int N_ROT       = 16;
    localparam int N_DROP      = 4;
    localparam int N_CLZ       = 26;
    localparam int N_LRCW_RAND = 10;
    localparam int N_REQ       = N_ARITH + N_OVF + N_GRAY + N_UNKNOWN + N_ROT + N_DROP
                               + N_CLZ + 2 + N_LRCW_RAND;
    // 40 cycles per request plus slack
    localparam int TIMEOUT     = 40 * N_REQ + 100;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              in_valid;
    logic [INST_W-1:0] inst;
    logic [DATA_W-1:0] data_a;
    logic [DATA_W-1:0] data_b;
    logic              busy;
    logic              out_valid;
    logic [DATA_W-1:0] data_out;

    int seed = 2;
    int cycle = 0;

    // scoreboard, expected value and the edge it should appear after
    logic [DATA_W-1:0] exp_q[$];
    int                exp_edge_q[$];
    bit                head_valid = 1'b0;
    logic [DATA_W-1:0] head_data = '0;
    int                head_cycle = 0;

    // iterative request in flight and its finish edge
    bit iter_active = 1'b0;
    int iter_end = 0;
    int accept_lat;

    alu_top DUT (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_in_valid  (in_valid),
        .i_inst      (inst),
        .i_data_a    (data_a),
        .i_data_b    (data_b),
        .o_busy      (busy),
        .o_out_valid (out_valid),
        .o_data      (data_out)
    );

    always #2 clk = ~clk;

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [DATA_W-1:0] rand16();
        int r;
        r = $random(seed);
        return r[DATA_W-1:0];
    endfunction

    // signed sum or difference, clamped to 16-bit range
    function automatic logic [DATA_W-1:0] sat_addsub(input logic sub,
                                                     input logic [DATA_W-1:0] a,
                                                     input logic [DATA_W-1:0] b);
        int sa;
        int sb;
        int r;
        sa = int'($signed(a));
        sb = int'($signed(b));
        r = sub ? (sa - sb) : (sa + sb);
        if (r > 32767) begin
            return 16'h7fff;
        end else if (r < -32768) begin
            return 16'h8000;
        end
        return r[DATA_W-1:0];
    endfunction

    function automatic logic [DATA_W-1:0] gray_code(input logic [DATA_W-1:0] a);
        logic [DATA_W-1:0] g;
        int i;
        for (i = 0; i < DATA_W - 1; i++) begin
            g[i] = a[i+1] ^ a[i];
        end
        g[DATA_W-1] = a[DATA_W-1];
        return g;
    endfunction

    function automatic logic [DATA_W-1:0] rotate_right(input logic [DATA_W-1:0] a,
                                                       input logic [3:0] n);
        logic [DATA_W-1:0] r;
        int i;
        r = a;
        for (i = 0; i < int'(n); i++) begin
            r = {r[0], r[DATA_W-1:1]};
        end
        return r;
    endfunction

    function automatic int count_lz(input logic [DATA_W-1:0] a);
        int n;
        int i;
        bit found;
        n = 0;
        found = 1'b0;
        for (i = DATA_W - 1; i >= 0; i--) begin
            if (!found && !a[i]) begin
                n++;
            end else begin
                found = 1'b1;
            end
        end
        return n;
    endfunction

    // a selects which of the 16 steps shift b
    function automatic logic [DATA_W-1:0] lrcw_ref(input logic [DATA_W-1:0] a,
                                                   input logic [DATA_W-1:0] b);
        logic [DATA_W-1:0] w;
        int i;
        w = b;
        for (i = 0; i < DATA_W; i++) begin
            if (a[i]) begin
                w = {w[DATA_W-2:0], ~w[DATA_W-1]};
            end
        end
        return w;
    endfunction

    function automatic bit is_iterative(input logic [INST_W-1:0] op);
        return (op == OP_ROT) || (op == OP_CLZ) || (op == OP_LRCW);
    endfunction

    function automatic logic [DATA_W-1:0] expected_result(input logic [INST_W-1:0] op,
                                                          input logic [DATA_W-1:0] a,
                                                          input logic [DATA_W-1:0] b);
        case (op)
            OP_ADD:  return sat_addsub(1'b0, a, b);
            OP_SUB:  return sat_addsub(1'b1, a, b);
            OP_GRAY: return gray_code(a);
            OP_ROT:  return rotate_right(a, b[3:0]);
            OP_CLZ:  return DATA_W'(count_lz(a));
            OP_LRCW: return lrcw_ref(a, b);
            default: return '0;
        endcase
    endfunction

    // edges from accept to the o_out_valid edge
    function automatic int expected_latency(input logic [INST_W-1:0] op,
                                            input logic [DATA_W-1:0] a,
                                            input logic [DATA_W-1:0] b);
        case (op)
            OP_ROT:  return int'(b[3:0]) + 2;
            OP_LRCW: return 18;
            OP_CLZ:  return (a == '0) ? 18 : count_lz(a) + 2;
            default: return 1;
        endcase
    endfunction

    // starts at a falling edge, waits out busy, holds the request one cycle
    task automatic issue_req(input logic [INST_W-1:0] op, input logic [DATA_W-1:0] a,
                             input logic [DATA_W-1:0] b);
        while (busy) begin
            in_valid = 1'b0;
            @(negedge clk);
        end
        in_valid = 1'b1;
        inst     = op;
        data_a   = a;
        data_b   = b;
        @(negedge clk);
    endtask

    task automatic idle_cycles(input int n);
        in_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    // request that must be dropped
    task automatic poke_while_busy(input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
        assert (busy) else stop_run("no busy window to drive the dropped request into");
        in_valid = 1'b1;
        inst     = OP_ADD;
        data_a   = a;
        data_b   = b;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // accept monitor and scoreboard bookkeeping, pre-edge values
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= TIMEOUT) begin
            stop_run($sformatf("timeout, run exceeded %0d cycles", TIMEOUT));
        end else if (rst_n) begin
            // result was checked on the falling edge before
            if (out_valid && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                void'(exp_edge_q.pop_front());
            end
            if (iter_active && cycle == iter_end) begin
                iter_active = 1'b0;
            end
            if (in_valid && !busy) begin
                accept_lat = expected_latency(inst, data_a, data_b);
                exp_q.push_back(expected_result(inst, data_a, data_b));
                exp_edge_q.push_back(cycle + accept_lat);
                if (is_iterative(inst)) begin
                    iter_active = 1'b1;
                    iter_end    = cycle + accept_lat;
                end
            end
            head_valid = (exp_q.size() > 0);
            if (head_valid) begin
                head_data  = exp_q[0];
                head_cycle = exp_edge_q[0];
            end
        end
    end

    // checks sample on the falling edge where outputs are settled
    result_expected: assert property (@(negedge clk) disable iff (!rst_n)
        out_valid |-> head_valid)
        else stop_run("o_out_valid pulsed with no request outstanding");

    result_value: assert property (@(negedge clk) disable iff (!rst_n)
        (out_valid && head_valid) |-> (data_out == head_data))
        else stop_run($sformatf("mismatch at time %0t: o_data %h, expected %h",
                                $time, data_out, head_data));

    result_timing: assert property (@(negedge clk) disable iff (!rst_n)
        (out_valid && head_valid) |-> (cycle == head_cycle))
        else stop_run($sformatf("result came after edge %0d, expected after edge %0d",
                                cycle, head_cycle));

    result_not_late: assert property (@(negedge clk) disable iff (!rst_n)
        head_valid |-> (cycle <= head_cycle))
        else stop_run("an expected result did not arrive in time");

    busy_window: assert property (@(negedge clk) disable iff (!rst_n)
        iter_active |-> busy)
        else stop_run("o_busy low while an iterative request is running");

    busy_idle: assert property (@(negedge clk) disable iff (!rst_n)
        !iter_active |-> !busy)
        else stop_run("o_busy high with no iterative request running");

    initial begin
        int i;
        logic [DATA_W-1:0] b;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        inst     = '0;
        data_a   = '0;
        data_b   = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        assert (!busy && !out_valid && data_out == '0)
            else stop_run("outputs not cleared by reset");
        // nothing requested, busy must stay low
        idle_cycles(5);

        // back-to-back add and sub
        for (i = 0; i < N_ARITH; i++) begin
            issue_req((i % 2 == 1) ? OP_SUB : OP_ADD, rand16(), rand16());
        end
        // overflow both ways
        issue_req(OP_ADD, 16'h7fff, 16'h0001);
        issue_req(OP_ADD, 16'h8000, 16'hffff);
        issue_req(OP_SUB, 16'h8000, 16'h0001);
        issue_req(OP_SUB, 16'h7fff, 16'hffff);
        issue_req(OP_ADD, 16'h7fff, 16'h8000);
        issue_req(OP_SUB, 16'h8000, 16'h8000);
        idle_cycles(2);

        for (i = 0; i < N_GRAY; i++) begin
            issue_req(OP_GRAY, rand16(), rand16());
        end
        // unused opcodes give zero
        issue_req(4'd9, rand16(), rand16());
        issue_req(4'd2, rand16(), rand16());
        issue_req(4'd15, rand16(), rand16());
        idle_cycles(2);

        // every rotate amount, some with a dropped request behind
        for (i = 0; i < N_ROT; i++) begin
            b = rand16();
            b[3:0] = i[3:0];
            issue_req(OP_ROT, rand16(), b);
            if (i % 4 == 0) begin
                poke_while_busy(rand16(), rand16());
            end
        end

        // leading one walks down, ends at zero
        for (i = 0; i <= DATA_W; i++) begin
            issue_req(OP_CLZ, DATA_W'(16'hffff >> i), rand16());
        end
        issue_req(OP_CLZ, 16'h8000, rand16());
        for (i = 0; i < 8; i++) begin
            issue_req(OP_CLZ, rand16() >> (i * 2), rand16());
        end

        issue_req(OP_LRCW, 16'h0000, rand16());
        issue_req(OP_LRCW, 16'hffff, rand16());
        for (i = 0; i < N_LRCW_RAND; i++) begin
            issue_req(OP_LRCW, rand16(), rand16());
        end

        // drain
        in_valid = 1'b0;
        while (head_valid || iter_active) begin
            @(negedge clk);
        end
        idle_cycles(4);
        if (exp_q.size() == 0 && !busy) begin
            $display("Regression passed");
            $finish;
        end else begin
            stop_run("results still outstanding at the end of the run");
        end
    end

endmodule

// File: vlog.f
alu_pkg.sv
alu_ctrl_fsm.sv
alu_step_counter.sv
alu_iter_unit.sv
alu_result_stage.sv
alu_top.sv
tb_alu.sv
